/* riscv_defines.sv */
//////////////////////////////
// rv32i execute stage definitions
// alu operation codes, operand select codes,
// request and response structs of the execute stage
//////////////////////////////

`default_nettype none

package riscv_defines;

  //////////////////////////////
  // alu operations
  //////////////////////////////

  // arithmetic, logic and shifts first, comparisons in the upper half
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLTS = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LTS  = 4'd12,
    ALU_GES  = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  //////////////////////////////
  // operand selects
  //////////////////////////////

  // zero as operand a turns an add into LUI
  typedef enum logic [1:0] {
    OP_A_RS1  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2
  } op_a_sel_e;

  typedef enum logic {
    OP_B_RS2 = 1'b0,
    OP_B_IMM = 1'b1
  } op_b_sel_e;

  //////////////////////////////
  // stage payloads
  //////////////////////////////

  // one decoded instruction from decode
  typedef struct packed {
    alu_op_e     alu_op;
    op_a_sel_e   op_a_sel;
    op_b_sel_e   op_b_sel;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
  } ex_req_t;

  // registered outcome of one instruction
  typedef struct packed {
    logic [31:0] result;
    logic        branch_taken;
    logic [31:0] target;
  } ex_rsp_t;

  // set-less-than and the six branch conditions
  function automatic logic is_cmp_op(alu_op_e op);
    return op inside {ALU_SLTS, ALU_SLTU, ALU_EQ, ALU_NE,
                      ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU};
  endfunction

endpackage

`default_nettype wire

/* riscv_alu.sv */
//////////////////////////////
// rv32i alu, area reduced
// one shared adder, one right shifter reused
// for left shifts, one comparator for all
// branch conditions and set-less-than
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_alu
(
  input  riscv_defines::alu_op_e operator_i,
  input  logic [31:0]            operand_a_i,
  input  logic [31:0]            operand_b_i,

  output logic [31:0]            result_o,
  output logic                   comparison_result_o
);

  import riscv_defines::*;

  //////////////////////////////
  // adder
  //////////////////////////////

  logic        adder_negate;
  logic [31:0] adder_in_b;
  logic [31:0] adder_result;

  // only sub negates b and every other op adds straight
  assign adder_negate = (operator_i == ALU_SUB);

  // two's complement of b as invert plus carry in
  assign adder_in_b = operand_b_i ^ {32{adder_negate}};

  // the single adder of the alu
  assign adder_result = operand_a_i + adder_in_b + {31'b0, adder_negate};

  //////////////////////////////
  // shifter
  //////////////////////////////

  logic        shift_left;
  logic        shift_arith;
  logic [4:0]  shift_amt;
  logic [31:0] operand_a_rev;
  logic [31:0] shift_op_a;
  logic [63:0] shift_op_a_ext;
  logic [63:0] shift_right_ext;
  logic [31:0] shift_right_result;
  logic [31:0] shift_left_result;
  logic [31:0] shift_result;

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);

  // rv32i shifts only look at the low five bits of b
  assign shift_amt = operand_b_i[4:0];

  // left shift as reverse, shift right and reverse back
  assign operand_a_rev = {<<{operand_a_i}};
  assign shift_op_a    = shift_left ? operand_a_rev : operand_a_i;

  // upper half is the fill source and holds the sign bit only for sra
  assign shift_op_a_ext = {{32{shift_arith & shift_op_a[31]}}, shift_op_a};

  assign shift_right_ext    = shift_op_a_ext >> shift_amt;
  assign shift_right_result = shift_right_ext[31:0];

  // undo the input reversal for sll
  assign shift_left_result = {<<{shift_right_result}};

  assign shift_result = shift_left ? shift_left_result : shift_right_result;

  //////////////////////////////
  // comparison
  //////////////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_greater;
  logic cmp_result;

  // signed forms of less-than and greater-equal
  always_comb
  begin
    cmp_signed = 1'b0;

    unique case (operator_i)
      ALU_SLTS,
      ALU_LTS,
      ALU_GES:
      begin
        cmp_signed = 1'b1;
      end

      default:
      begin
        cmp_signed = 1'b0;
      end
    endcase
  end

  assign is_equal = (operand_a_i == operand_b_i);

  // 33 bit compare with bit 31 copied up as sign only for signed ops
  assign is_greater = $signed({operand_a_i[31] & cmp_signed, operand_a_i})
                      >
                      $signed({operand_b_i[31] & cmp_signed, operand_b_i});

  // all conditions from equal and greater
  always_comb
  begin
    cmp_result = 1'b0;

    unique case (operator_i)
      ALU_EQ:            cmp_result = is_equal;
      ALU_NE:            cmp_result = ~is_equal;
      ALU_GES, ALU_GEU:  cmp_result = is_greater | is_equal;
      ALU_LTS, ALU_LTU,
      ALU_SLTS, ALU_SLTU: cmp_result = ~(is_greater | is_equal);

      default:           cmp_result = 1'b0;
    endcase
  end

  // quiet outside of compare ops so a stray branch flag sees zero
  assign comparison_result_o = is_cmp_op(operator_i) & cmp_result;

  //////////////////////////////
  // result mux
  //////////////////////////////

  always_comb
  begin
    result_o = '0;

    unique case (operator_i)
      // logic
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;

      // adder
      ALU_ADD,
      ALU_SUB: result_o = adder_result;

      // shifter
      ALU_SLL,
      ALU_SRL,
      ALU_SRA: result_o = shift_result;

      // set-less-than and branch compares, zero extended
      ALU_SLTS, ALU_SLTU,
      ALU_EQ,   ALU_NE,
      ALU_LTS,  ALU_GES,
      ALU_LTU,  ALU_GEU: result_o = {31'b0, cmp_result};

      default: result_o = '0;
    endcase
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // an unknown opcode would silently fall through to a zero result
  always_comb
  begin
    assert (!$isunknown(operator_i))
      else $error("alu: operator_i is unknown");
  end

endmodule

`default_nettype wire

/* riscv_branch_unit.sv */
//////////////////////////////
// rv32i branch unit
// target adder, taken decision and link value
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_branch_unit
(
  input  logic [31:0] pc_i,
  input  logic [31:0] rs1_i,
  input  logic [31:0] imm_i,
  input  logic        is_branch_i,
  input  logic        is_jal_i,
  input  logic        is_jalr_i,
  input  logic        cmp_result_i,

  output logic [31:0] target_o,
  output logic        taken_o,
  output logic [31:0] link_o
);

  logic [31:0] target_base;
  logic [31:0] target_sum;

  // jalr is register relative, jal and branches are pc relative
  assign target_base = is_jalr_i ? rs1_i : pc_i;

  // separate adder, the alu is busy with the compare
  assign target_sum = target_base + imm_i;

  // jalr drops bit 0 of the sum
  assign target_o = {target_sum[31:1], target_sum[0] & ~is_jalr_i};

  // jumps always go, branches only on a true compare
  assign taken_o = (is_branch_i & cmp_result_i) | is_jal_i | is_jalr_i;

  // return address for jal / jalr
  assign link_o = pc_i + 32'd4;

  // decode marks one control flow kind at most
  always_comb
  begin
    assert ($onehot0({is_branch_i, is_jal_i, is_jalr_i}))
      else $error("branch unit: more than one control flow flag set");
  end

endmodule

`default_nettype wire

/* riscv_ex_stage.sv */
//////////////////////////////
// rv32i execute stage
// operand select, alu, branch unit and
// a one cycle response register
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module riscv_ex_stage
(
  input  logic                   clk,
  input  logic                   rst_n_i,

  input  logic                   req_valid_i,
  input  riscv_defines::ex_req_t req_i,

  output logic                   rsp_valid_o,
  output riscv_defines::ex_rsp_t rsp_o
);

  import riscv_defines::*;

  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [31:0] alu_result;
  logic        alu_cmp;
  logic [31:0] br_target;
  logic        br_taken;
  logic [31:0] br_link;
  ex_rsp_t     rsp_d;

  //////////////////////////////
  // operand select
  //////////////////////////////

  // pc for auipc, zero for lui
  always_comb
  begin
    unique case (req_i.op_a_sel)
      OP_A_RS1:  operand_a = req_i.rs1;
      OP_A_PC:   operand_a = req_i.pc;
      OP_A_ZERO: operand_a = '0;
      default:   operand_a = '0;
    endcase
  end

  assign operand_b = (req_i.op_b_sel == OP_B_IMM) ? req_i.imm : req_i.rs2;

  //////////////////////////////
  // datapath
  //////////////////////////////

  riscv_alu alu_inst
  (
    .operator_i          (req_i.alu_op),
    .operand_a_i         (operand_a),
    .operand_b_i         (operand_b),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp)
  );

  riscv_branch_unit branch_unit_inst
  (
    .pc_i         (req_i.pc),
    .rs1_i        (req_i.rs1),
    .imm_i        (req_i.imm),
    .is_branch_i  (req_i.is_branch),
    .is_jal_i     (req_i.is_jal),
    .is_jalr_i    (req_i.is_jalr),
    .cmp_result_i (alu_cmp),
    .target_o     (br_target),
    .taken_o      (br_taken),
    .link_o       (br_link)
  );

  // jumps write the link, branches report the compare bit
  always_comb
  begin
    rsp_d.branch_taken = br_taken;
    rsp_d.target       = br_target;

    if (req_i.is_jal || req_i.is_jalr)
    begin
      rsp_d.result = br_link;
    end
    else if (req_i.is_branch)
    begin
      rsp_d.result = {31'b0, alu_cmp};
    end
    else
    begin
      rsp_d.result = alu_result;
    end
  end

  //////////////////////////////
  // response register
  //////////////////////////////

  // payload only loads on a strobe and holds otherwise
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
    end
    else
    begin
      rsp_valid_o <= req_valid_i;
      if (req_valid_i)
      begin
        rsp_o <= rsp_d;
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // a registered jalr target is always halfword aligned
  assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_valid_o && $past(req_i.is_jalr) |-> !rsp_o.target[0]);

  // nothing comes out right after reset
  assert property (@(posedge clk) $rose(rst_n_i) |-> !rsp_valid_o);

  // exactly one cycle from strobe to response, in both directions
  assert property (@(posedge clk) disable iff (!rst_n_i)
    req_valid_i |=> rsp_valid_o);

  assert property (@(posedge clk) disable iff (!rst_n_i)
    !req_valid_i |=> !rsp_valid_o);

endmodule

`default_nettype wire

/* tb_riscv_ex_stage.sv */
//////////////////////////////
// testbench for the rv32i execute stage
// directed tests checked against a reference model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_riscv_ex_stage;

  import riscv_defines::*;

  // the tests need about 700 cycles and the limit leaves a wide margin
  localparam int MAX_CYCLES = 2000;

  logic        clk;
  logic        rst_n_i;
  logic        req_valid_i;
  ex_req_t     req_i;
  logic        rsp_valid_o;
  ex_rsp_t     rsp_o;

  logic [31:0] lcg_state;
  ex_rsp_t     expected_rsp;
  int          cycle_count;

  riscv_ex_stage riscv_ex_stage_inst
  (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  // 20 ns period
  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $fatal(1, "cycle limit reached");
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // plain request without control flow flags
  function automatic ex_req_t make_req(alu_op_e op, op_a_sel_e a_sel, op_b_sel_e b_sel,
                                       logic [31:0] pc, logic [31:0] rs1,
                                       logic [31:0] rs2, logic [31:0] imm);
    ex_req_t req;
    req          = '0;
    req.alu_op   = op;
    req.op_a_sel = a_sel;
    req.op_b_sel = b_sel;
    req.pc       = pc;
    req.rs1      = rs1;
    req.rs2      = rs2;
    req.imm      = imm;
    return req;
  endfunction

  // high lcg bits pick op, selects and kind
  function automatic ex_req_t random_req();
    ex_req_t     req;
    logic [31:0] sel;
    sel          = next_rand();
    req          = '0;
    req.alu_op   = alu_op_e'(sel[31:28]);
    req.op_a_sel = (sel[27:26] == 2'd3) ? OP_A_ZERO : op_a_sel_e'(sel[27:26]);
    req.op_b_sel = op_b_sel_e'(sel[25]);
    req.pc       = next_rand() & 32'hffff_fffc;
    req.rs1      = next_rand();
    req.rs2      = next_rand();
    req.imm      = next_rand();
    // at most one control flow kind
    case (sel[24:23])
      2'd0:    req.is_branch = 1'b1;
      2'd1:    req.is_jal    = 1'b1;
      2'd2:    req.is_jalr   = 1'b1;
      default: req.is_branch = 1'b0;
    endcase
    return req;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  // comparison bit is zero for non-compare ops
  function automatic logic compare_bit(alu_op_e op, logic [31:0] a, logic [31:0] b);
    if (!is_cmp_op(op))
    begin
      return 1'b0;
    end
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LTS, ALU_SLTS: return $signed(a) < $signed(b);
      ALU_GES:           return $signed(a) >= $signed(b);
      ALU_LTU, ALU_SLTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_value(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [4:0] amount;
    // only five bits of b count for shifts
    amount = b[4:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << amount;
      ALU_SRL: return a >> amount;
      ALU_SRA: return $unsigned($signed(a) >>> amount);
      default: return {31'b0, compare_bit(op, a, b)};
    endcase
  endfunction

  function automatic ex_rsp_t response_of(ex_req_t req);
    ex_rsp_t     rsp;
    logic [31:0] a;
    logic [31:0] b;
    logic        cmp;
    logic [31:0] sum;
    case (req.op_a_sel)
      OP_A_PC:   a = req.pc;
      OP_A_ZERO: a = '0;
      default:   a = req.rs1;
    endcase
    b   = (req.op_b_sel == OP_B_IMM) ? req.imm : req.rs2;
    cmp = compare_bit(req.alu_op, a, b);
    sum = req.rs1 + req.imm;
    // jalr clears bit 0 and all others are pc relative
    rsp.target       = req.is_jalr ? {sum[31:1], 1'b0} : req.pc + req.imm;
    rsp.branch_taken = (req.is_branch & cmp) | req.is_jal | req.is_jalr;
    if (req.is_jal || req.is_jalr)
    begin
      rsp.result = req.pc + 32'd4;
    end
    else if (req.is_branch)
    begin
      rsp.result = {31'b0, cmp};
    end
    else
    begin
      rsp.result = alu_value(req.alu_op, a, b);
    end
    return rsp;
  endfunction

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
    $display("** FAIL **");
    $fatal(1, "value mismatch");
  endtask

  task automatic check_rsp(input ex_rsp_t expected, input ex_rsp_t actual);
    if (actual.result !== expected.result)
    begin
      report_mismatch("rsp_o.result", expected.result, actual.result);
    end
    else if (actual.branch_taken !== expected.branch_taken)
    begin
      report_mismatch("rsp_o.branch_taken", {31'b0, expected.branch_taken},
                      {31'b0, actual.branch_taken});
    end
    else if (actual.target !== expected.target)
    begin
      report_mismatch("rsp_o.target", expected.target, actual.target);
    end
  endtask

  task automatic check_valid(input logic expected);
    if (rsp_valid_o !== expected)
    begin
      report_mismatch("rsp_valid_o", {31'b0, expected}, {31'b0, rsp_valid_o});
    end
  endtask

  // called at a falling edge and checks one cycle later at the next one
  task automatic drive_and_check(input logic valid, input ex_req_t req);
    req_valid_i = valid;
    req_i       = req;
    // idle cycles keep the old payload
    if (valid)
    begin
      expected_rsp = response_of(req);
    end
    @(posedge clk);
    @(negedge clk);
    check_valid(valid);
    check_rsp(expected_rsp, rsp_o);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic idle_after_reset();
    for (int i = 0; i < 4; i++)
    begin
      drive_and_check(1'b0, random_req());
    end
  endtask

  task automatic arith_logic_ops();
    alu_op_e   ops [5] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
    op_a_sel_e a_sel;
    op_b_sel_e b_sel;
    for (int k = 0; k < 5; k++)
    begin
      for (int i = 0; i < 100; i++)
      begin
        // rs1, pc and zero (lui) in turn
        case (i % 3)
          0:       a_sel = OP_A_RS1;
          1:       a_sel = OP_A_PC;
          default: a_sel = OP_A_ZERO;
        endcase
        b_sel = (i % 2 == 0) ? OP_B_RS2 : OP_B_IMM;
        drive_and_check(1'b1, make_req(ops[k], a_sel, b_sel, next_rand() & 32'hffff_fffc,
                                       next_rand(), next_rand(), next_rand()));
      end
    end
  endtask

  task automatic shift_ops();
    alu_op_e     ops [3] = '{ALU_SLL, ALU_SRL, ALU_SRA};
    logic [31:0] value;
    logic [31:0] amount;
    for (int k = 0; k < 3; k++)
    begin
      for (int i = 0; i < 20; i++)
      begin
        value = next_rand();
        // every other value negative for the sra fill
        if (i % 2 == 1)
        begin
          value = value | 32'h8000_0000;
        end
        // full width amounts are nearly all above 31
        amount = next_rand();
        drive_and_check(1'b1, make_req(ops[k], OP_A_RS1,
                                       (i % 4 < 2) ? OP_B_RS2 : OP_B_IMM,
                                       32'h0000_1000, value, amount, amount));
      end
    end
  endtask

  task automatic set_less_than();
    logic [31:0] lhs [5] = '{32'h8000_0000, 32'h7fff_ffff, 32'h0000_1234,
                             32'hffff_ffff, 32'h0000_0001};
    logic [31:0] rhs [5] = '{32'h7fff_ffff, 32'h8000_0000, 32'h0000_1234,
                             32'h0000_0001, 32'hffff_ffff};
    alu_op_e     op;
    for (int k = 0; k < 2; k++)
    begin
      op = (k == 0) ? ALU_SLTS : ALU_SLTU;
      // edge pairs
      for (int i = 0; i < 5; i++)
      begin
        drive_and_check(1'b1, make_req(op, OP_A_RS1, OP_B_RS2, '0, lhs[i], rhs[i], '0));
      end
      for (int i = 0; i < 20; i++)
      begin
        drive_and_check(1'b1, make_req(op, OP_A_RS1, (i % 2 == 0) ? OP_B_RS2 : OP_B_IMM,
                                       '0, next_rand(), next_rand(), next_rand()));
      end
    end
  endtask

  task automatic control_flow();
    alu_op_e     conds [6] = '{ALU_EQ, ALU_NE, ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU};
    // equal, signed less, signed greater, unsigned less
    logic [31:0] lhs [4] = '{32'd7, 32'hffff_fffb, 32'd3, 32'd2};
    logic [31:0] rhs [4] = '{32'd7, 32'd3, 32'hffff_fffb, 32'd9};
    ex_req_t     req;
    for (int k = 0; k < 6; k++)
    begin
      for (int i = 0; i < 4; i++)
      begin
        req = make_req(conds[k], OP_A_RS1, OP_B_RS2, next_rand() & 32'hffff_fffc,
                       lhs[i], rhs[i], next_rand() & 32'h0000_1ffe);
        req.is_branch = 1'b1;
        drive_and_check(1'b1, req);
      end
    end
    // jal returns the link in result
    req = make_req(ALU_ADD, OP_A_PC, OP_B_IMM, next_rand() & 32'hffff_fffc,
                   next_rand(), next_rand(), next_rand() & 32'h000f_fffe);
    req.is_jal = 1'b1;
    drive_and_check(1'b1, req);
    // odd rs1 and even imm make every jalr sum odd
    for (int i = 0; i < 4; i++)
    begin
      req = make_req(ALU_ADD, OP_A_RS1, OP_B_IMM, next_rand() & 32'hffff_fffc,
                     next_rand() | 32'd1, next_rand(), next_rand() & 32'hffff_fffe);
      req.is_jalr = 1'b1;
      drive_and_check(1'b1, req);
    end
  endtask

  task automatic streaming();
    for (int i = 0; i < 50; i++)
    begin
      drive_and_check(1'b1, random_req());
      // two idle cycles after every tenth strobe while the payload holds
      if (i % 10 == 9)
      begin
        drive_and_check(1'b0, random_req());
        drive_and_check(1'b0, random_req());
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    lcg_state    = 32'd43969;
    expected_rsp = '0;
    cycle_count  = 0;
    // reset spans three rising edges and is released on a falling edge
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    idle_after_reset();
    arith_logic_ops();
    shift_ops();
    set_less_than();
    control_flow();
    streaming();
    drive_and_check(1'b0, random_req());

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
riscv_defines.sv
riscv_alu.sv
riscv_branch_unit.sv
riscv_ex_stage.sv
tb_riscv_ex_stage.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_riscv_ex_stage
FILELIST = flist.f
BUILD    = obj_dir

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
